/* project.f */
+incdir+testbench
hdl/lbp_pkg.sv
hdl/window_5x5.sv
hdl/ni_encoder.sv
hdl/rd_encoder.sv
hdl/riu2_combiner.sv
hdl/mrelbp_top.sv
testbench/tb_mrelbp.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_mrelbp -f project.f

output=$(./obj_dir/Vtb_mrelbp)
echo "$output"

if grep -q "TB PASSED" <<< "$output"; then
  exit 0
else
  echo "simulation reported failure"
  exit 1
fi

/* testbench/tb_model.svh */
// whole stored image indexed [row][col]
typedef logic [ROWS-1:0][COLS-1:0][PIX_W-1:0] image_t;

// (row,col) offsets with k=0 pointing right and k stepping counterclockwise
localparam int off_row [8] = '{0, -1, -1, -1, 0, 1, 1, 1};
localparam int off_col [8] = '{1, 1, 0, -1, -1, -1, 0, 1};

function automatic int pix(image_t im, int r, int c);
  return int'(im[r][c]);
endfunction

// bit k set when 25 times the radius-2 sample reaches the patch sum
function automatic logic [7:0] model_ni(image_t im, int cr, int cc);
  int         sum;
  logic [7:0] code;
  sum = 0;
  for (int dr = -2; dr <= 2; dr++) begin
    for (int dc = -2; dc <= 2; dc++) begin
      sum = sum + pix(im, cr + dr, cc + dc);
    end
  end
  for (int k = 0; k < 8; k++) begin
    code[k] = (NI_GAIN * pix(im, cr + 2 * off_row[k], cc + 2 * off_col[k])) >= sum;
  end
  return code;
endfunction

// bit k set when the outer sample is not below the inner one
function automatic logic [7:0] model_rd(image_t im, int cr, int cc);
  logic [7:0] code;
  for (int k = 0; k < 8; k++) begin
    code[k] = pix(im, cr + 2 * off_row[k], cc + 2 * off_col[k]) >=
              pix(im, cr + off_row[k], cc + off_col[k]);
  end
  return code;
endfunction

// uniform codes give their popcount and everything else gives 9
function automatic logic [LBL_W-1:0] model_riu2(logic [7:0] code);
  int trans;
  int ones;
  trans = 0;
  ones  = 0;
  for (int k = 0; k < 8; k++) begin
    trans = trans + int'(code[k] != code[(k + 1) % 8]);
    ones  = ones + int'(code[k]);
  end
  return (trans <= 2) ? LBL_W'(ones) : LBL_W'(9);
endfunction

// the centre sits two rows up and two columns left of the completing pixel r,c
function automatic label_t model_label(image_t im, int r, int c);
  label_t lbl;
  lbl.ni = model_riu2(model_ni(im, r - 2, c - 2));
  lbl.rd = model_riu2(model_rd(im, r - 2, c - 2));
  return lbl;
endfunction

/* testbench/tb_mrelbp.sv */
`timescale 1ns/1ns

module tb_mrelbp;

  import lbp_pkg::*;

  `include "tb_model.svh"

  logic   clk;
  logic   rst_i;
  logic   valid_i;
  pixel_t pix_i;
  logic   valid_o;
  label_t label_o;

  // marks strobes whose pixel completes a window
  logic   strobe_qual;
  int     cyc;
  int     seed;
  int     errors;
  int     checks;
  int     tests_run;
  int     tests_failed;
  int     lat;
  label_t exp_q [$];
  label_t got_q [$];
  int     qual_cyc [$];
  image_t img;

  mrelbp_top uut (
    .clk     (clk),
    .rst_i   (rst_i),
    .valid_i (valid_i),
    .pix_i   (pix_i),
    .valid_o (valid_o),
    .label_o (label_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  initial begin
    repeat (20000) @(posedge clk);
    $display("watchdog expired before all tests finished");
    $display("TB FAILED");
    $finish;
  end

  task automatic check_val(string name, logic [31:0] expv, logic [31:0] act);
    checks++;
    if (expv !== act) begin
      $display("Error: %s expected 0x%0h, got 0x%0h", name, expv, act);
      errors++;
    end
  endtask

  // strobe and output monitor on the falling edge
  always @(negedge clk) begin
    if (!rst_i) begin
      if (valid_i && strobe_qual) begin
        qual_cyc.push_back(cyc);
      end
      if (valid_o) begin
        got_q.push_back(label_o);
        if (qual_cyc.size() == 0) begin
          $display("output on valid_o with no qualifying input strobe before it");
          errors++;
        end else begin
          lat = cyc - qual_cyc.pop_front();
          check_val("valid_o latency", 4, lat);
        end
      end
    end
  end

  task automatic send_frame(image_t im, int nrows, bit gaps);
    int rnd;
    for (int r = 0; r < nrows; r++) begin
      for (int c = 0; c < COLS; c++) begin
        @(posedge clk);
        valid_i     <= 1'b1;
        pix_i.sof   <= (r == 0) && (c == 0);
        pix_i.data  <= im[r][c];
        strobe_qual <= (r >= 4) && (c >= 4);
        if (gaps) begin
          rnd = $random(seed);
          repeat (rnd[1:0]) begin
            @(posedge clk);
            valid_i     <= 1'b0;
            strobe_qual <= 1'b0;
          end
        end
      end
    end
    @(posedge clk);
    valid_i     <= 1'b0;
    strobe_qual <= 1'b0;
  endtask

  task automatic wait_outputs(int n);
    int waited;
    waited = 0;
    while ((got_q.size() < n) && (waited < 2000)) begin
      @(posedge clk);
      waited++;
    end
    if (got_q.size() < n) begin
      $display("timed out waiting for %0d outputs, only %0d arrived", n, got_q.size());
      errors++;
    end
    // settle period so that any extra output gets counted
    repeat (30) @(posedge clk);
  endtask

  task automatic compare_outputs();
    check_val("valid_o count", exp_q.size(), got_q.size());
    for (int i = 0; (i < exp_q.size()) && (i < got_q.size()); i++) begin
      check_val("label_o.ni", 32'(exp_q[i].ni), 32'(got_q[i].ni));
      check_val("label_o.rd", 32'(exp_q[i].rd), 32'(got_q[i].rd));
    end
  endtask

  task automatic clear_queues();
    exp_q.delete();
    got_q.delete();
    qual_cyc.delete();
  endtask

  task automatic build_expected(image_t im);
    for (int r = 4; r < ROWS; r++) begin
      for (int c = 4; c < COLS; c++) begin
        exp_q.push_back(model_label(im, r, c));
      end
    end
  endtask

  task automatic end_test(string name, int err0);
    tests_run++;
    if (errors != err0) begin
      tests_failed++;
    end
    $display("test %s finished with %0d errors", name, errors - err0);
  endtask

  task automatic test_idle();
    int err0;
    err0 = errors;
    clear_queues();
    for (int i = 0; i < 20; i++) begin
      @(negedge clk);
      check_val("valid_o", 0, 32'(valid_o));
    end
    check_val("valid_o count", 0, got_q.size());
    end_test("idle", err0);
  endtask

  task automatic test_flat();
    int     err0;
    label_t lbl;
    err0 = errors;
    clear_queues();
    img = '0;
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        img[r][c] = 8'h5a;
      end
    end
    // every comparison ties, so all eight bits are set
    lbl.ni = 4'd8;
    lbl.rd = 4'd8;
    repeat (16) exp_q.push_back(lbl);
    send_frame(img, ROWS, 1'b0);
    wait_outputs(16);
    compare_outputs();
    end_test("flat", err0);
  endtask

  task automatic test_ramp();
    int err0;
    err0 = errors;
    clear_queues();
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        img[r][c] = 8'(16 * c);
      end
    end
    build_expected(img);
    send_frame(img, ROWS, 1'b0);
    wait_outputs(16);
    compare_outputs();
    end_test("ramp", err0);
  endtask

  task automatic test_random();
    int err0;
    int rnd;
    err0 = errors;
    clear_queues();
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        rnd = $random(seed);
        img[r][c] = rnd[7:0];
      end
    end
    build_expected(img);
    send_frame(img, ROWS, 1'b1);
    wait_outputs(16);
    compare_outputs();
    end_test("random_gaps", err0);
  endtask

  task automatic test_abort();
    int err0;
    int rnd;
    err0 = errors;
    clear_queues();
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        rnd = $random(seed);
        img[r][c] = rnd[7:0];
      end
    end
    // abort after three rows and restart with sof
    send_frame(img, 3, 1'b0);
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        img[r][c] = 8'((r * 29 + c * 53) ^ (r << 4));
      end
    end
    build_expected(img);
    send_frame(img, ROWS, 1'b0);
    wait_outputs(16);
    compare_outputs();
    end_test("abort_restart", err0);
  endtask

  initial begin
    rst_i        = 1'b1;
    valid_i      = 1'b0;
    pix_i        = '0;
    strobe_qual  = 1'b0;
    cyc          = 0;
    seed         = 32'hafe1c034;
    errors       = 0;
    checks       = 0;
    tests_run    = 0;
    tests_failed = 0;
    img          = '0;
    repeat (5) @(posedge clk);
    rst_i <= 1'b0;
    test_idle();
    test_flat();
    test_ramp();
    test_random();
    test_abort();
    $display("tests run %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* hdl/mrelbp_top.sv */
`timescale 1ns/1ns

module mrelbp_top (
  input  logic             clk,
  input  logic             rst_i,
  input  logic             valid_i,
  input  lbp_pkg::pixel_t  pix_i,
  output logic             valid_o,
  output lbp_pkg::label_t  label_o
);

  import lbp_pkg::*;

  logic    win_valid;
  window_t win;
  logic    ni_valid;
  code_t   ni_code;
  logic    rd_valid;
  code_t   rd_code;

  window_5x5 u_window (
    .clk         (clk),
    .rst_i       (rst_i),
    .valid_i     (valid_i),
    .pix_i       (pix_i),
    .win_valid_o (win_valid),
    .win_o       (win)
  );

  // both encoders see the same window on the same cycle
  ni_encoder u_ni (
    .clk         (clk),
    .rst_i       (rst_i),
    .win_valid_i (win_valid),
    .win_i       (win),
    .valid_o     (ni_valid),
    .code_o      (ni_code)
  );

  rd_encoder u_rd (
    .clk         (clk),
    .rst_i       (rst_i),
    .win_valid_i (win_valid),
    .win_i       (win),
    .valid_o     (rd_valid),
    .code_o      (rd_code)
  );

  riu2_combiner u_comb (
    .clk        (clk),
    .rst_i      (rst_i),
    .ni_valid_i (ni_valid),
    .rd_valid_i (rd_valid),
    .ni_i       (ni_code),
    .rd_i       (rd_code),
    .valid_o    (valid_o),
    .label_o    (label_o)
  );

endmodule

/* hdl/riu2_combiner.sv */
`timescale 1ns/1ns

module riu2_combiner (
  input  logic             clk,
  input  logic             rst_i,
  input  logic             ni_valid_i,
  input  logic             rd_valid_i,
  input  lbp_pkg::code_t   ni_i,
  input  lbp_pkg::code_t   rd_i,
  output logic             valid_o,
  output lbp_pkg::label_t  label_o
);

  import lbp_pkg::*;

  label_t label_d;
  label_t label_q;

  // uniform codes map to their popcount and all others to one shared bin
  function automatic logic [LBL_W-1:0] riu2_label(code_t c);
    logic [LBL_W-1:0] trans;
    logic [LBL_W-1:0] ones;
    trans = '0;
    ones  = '0;
    for (int k = 0; k < DIRS; k++) begin
      // bit 7 wraps round to bit 0
      trans = trans + LBL_W'(c.bits[k] ^ c.bits[(k + 1) % DIRS]);
      ones  = ones + LBL_W'(c.bits[k]);
    end
    return (trans <= LBL_W'(2)) ? ones : LBL_W'(RIU2_NONUNI);
  endfunction

  always_comb begin
    label_d.ni = riu2_label(ni_i);
    label_d.rd = riu2_label(rd_i);
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= ni_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (ni_valid_i) begin
      label_q <= label_d;
    end
  end

  assign label_o = label_q;

  // both encoders are built with equal latency from the same window strobe
  a_valid_align: assert property (
    @(posedge clk) disable iff (rst_i) ni_valid_i == rd_valid_i
  );

endmodule

/* hdl/rd_encoder.sv */
`timescale 1ns/1ns

module rd_encoder (
  input  logic              clk,
  input  logic              rst_i,
  input  logic              win_valid_i,
  input  lbp_pkg::window_t  win_i,
  output logic              valid_o,
  output lbp_pkg::code_t    code_o
);

  import lbp_pkg::*;

  ring_t ring;
  code_t code_d;
  code_t bits_q;
  code_t code_q;
  logic  v1_q;

  // outer sample against inner sample in the same direction
  always_comb begin
    ring = get_ring(win_i);
    for (int k = 0; k < DIRS; k++) begin
      code_d.bits[k] = ring.r2[k] >= ring.r1[k];
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      v1_q    <= 1'b0;
      valid_o <= 1'b0;
    end else begin
      v1_q    <= win_valid_i;
      valid_o <= v1_q;
    end
  end

  // second stage only balances latency against the NI path
  always_ff @(posedge clk) begin
    bits_q <= code_d;
    code_q <= bits_q;
  end

  assign code_o = code_q;

endmodule

/* hdl/ni_encoder.sv */
`timescale 1ns/1ns

module ni_encoder (
  input  logic              clk,
  input  logic              rst_i,
  input  logic              win_valid_i,
  input  lbp_pkg::window_t  win_i,
  output logic              valid_o,
  output lbp_pkg::code_t    code_o
);

  import lbp_pkg::*;

  ring_t                      ring;
  logic [SUM_W-1:0]           patch_sum;
  logic [SUM_W-1:0]           sum_q;
  logic [DIRS-1:0][PIX_W-1:0] r2_q;
  logic                       v1_q;
  code_t                      code_d;
  code_t                      code_q;

  // adder tree over all 25 pixels
  always_comb begin
    ring      = get_ring(win_i);
    patch_sum = '0;
    for (int i = 0; i < PATCH_N; i++) begin
      patch_sum = patch_sum + SUM_W'(ring.patch[i]);
    end
  end

  // gain times sample against the patch sum equals sample against the mean
  always_comb begin
    for (int k = 0; k < DIRS; k++) begin
      code_d.bits[k] = (SUM_W'(NI_GAIN) * SUM_W'(r2_q[k])) >= sum_q;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      v1_q    <= 1'b0;
      valid_o <= 1'b0;
    end else begin
      v1_q    <= win_valid_i;
      valid_o <= v1_q;
    end
  end

  always_ff @(posedge clk) begin
    sum_q  <= patch_sum;
    r2_q   <= ring.r2;
    code_q <= code_d;
  end

  assign code_o = code_q;

  a_sum_range: assert property (
    @(posedge clk) disable iff (rst_i) v1_q |-> (sum_q <= SUM_W'(MAX_SUM))
  );

endmodule

/* hdl/window_5x5.sv */
`timescale 1ns/1ns

module window_5x5 (
  input  logic              clk,
  input  logic              rst_i,
  input  logic              valid_i,
  input  lbp_pkg::pixel_t   pix_i,
  output logic              win_valid_o,
  output lbp_pkg::window_t  win_o
);

  import lbp_pkg::*;

  logic [COL_CNT_W-1:0] col_q;
  logic [ROW_W-1:0]     row_q;
  logic [COL_CNT_W-1:0] cur_col;
  logic [ROW_W-1:0]     cur_row;
  logic [COL_IDX_W-1:0] rd_idx;
  logic                 win_full;

  // per column [0] holds the previous row and [LB_N-1] the oldest
  logic [LB_N-1:0][PIX_W-1:0] line_mem [COLS];

  window_t win_q;

  // sof forces this pixel to position (0,0)
  always_comb begin
    cur_col = pix_i.sof ? '0 : col_q;
    cur_row = pix_i.sof ? '0 : row_q;
  end

  assign rd_idx = cur_col[COL_IDX_W-1:0];

  // enough rows and columns seen for a full interior window
  assign win_full = (cur_row >= ROW_W'(WIN_N - 1)) &&
                    (cur_col >= COL_CNT_W'(WIN_N - 1));

  always_ff @(posedge clk) begin
    if (rst_i) begin
      col_q       <= '0;
      row_q       <= '0;
      win_valid_o <= 1'b0;
    end else begin
      win_valid_o <= valid_i && win_full;
      if (valid_i) begin
        if (cur_col == COL_CNT_W'(COLS - 1)) begin
          col_q <= '0;
          // wrap to the top once the last row ends
          row_q <= (cur_row == ROW_W'(ROWS - 1)) ? '0 : cur_row + 1'b1;
        end else begin
          col_q <= cur_col + 1'b1;
          row_q <= cur_row;
        end
      end
    end
  end

  // line buffers and the register window move only on a strobe
  always_ff @(posedge clk) begin
    if (valid_i) begin
      line_mem[rd_idx] <= {line_mem[rd_idx][LB_N-2:0], pix_i.data};

      // shift every row one column towards col 0
      for (int rr = 0; rr < WIN_N; rr++) begin
        for (int cc = 0; cc < WIN_N - 1; cc++) begin
          win_q.px[rr][cc] <= win_q.px[rr][cc+1];
        end
      end

      // new right-hand column with the oldest row on top
      for (int rr = 0; rr < LB_N; rr++) begin
        win_q.px[rr][WIN_N-1] <= line_mem[rd_idx][LB_N-1-rr];
      end
      win_q.px[WIN_N-1][WIN_N-1] <= pix_i.data;
    end
  end

  assign win_o = win_q;

  // column counter must wrap before the spare bit is ever needed
  a_col_range: assert property (
    @(posedge clk) disable iff (rst_i) col_q < COL_CNT_W'(COLS)
  );

endmodule

/* hdl/lbp_pkg.sv */
package lbp_pkg;

  // image geometry
  localparam int COLS = 8;
  localparam int ROWS = 8;

  // datapath widths
  localparam int PIX_W = 8;
  localparam int SUM_W = 13;
  localparam int LBL_W = 4;

  // 5x5 neighbourhood centred at (2,2)
  localparam int WIN_N = 5;
  localparam int WIN_C = WIN_N / 2;
  localparam int LB_N = WIN_N - 1;
  localparam int PATCH_N = WIN_N * WIN_N;
  localparam int DIRS = 8;

  // counter widths; the column counter has one spare bit
  localparam int COL_IDX_W = $clog2(COLS);
  localparam int COL_CNT_W = COL_IDX_W + 1;
  localparam int ROW_W = $clog2(ROWS);

  // NI gain equals the patch size so that gain*sample compares to the patch sum
  localparam int NI_GAIN = 25;
  localparam int MAX_SUM = PATCH_N * ((1 << PIX_W) - 1);

  // riu2 label for non-uniform codes
  localparam int RIU2_NONUNI = DIRS + 1;

  // direction 0 points right and k steps counterclockwise by 45 degrees
  localparam int DIR_DR [DIRS] = '{0, -1, -1, -1, 0, 1, 1, 1};
  localparam int DIR_DC [DIRS] = '{1, 1, 0, -1, -1, -1, 0, 1};

  typedef struct packed {
    logic             sof;
    logic [PIX_W-1:0] data;
  } pixel_t;

  // row 0 and col 0 of px[row][col] hold the oldest pixels
  typedef struct packed {
    logic [WIN_N-1:0][WIN_N-1:0][PIX_W-1:0] px;
  } window_t;

  typedef struct packed {
    logic [DIRS-1:0][PIX_W-1:0]    r1;
    logic [DIRS-1:0][PIX_W-1:0]    r2;
    logic [PATCH_N-1:0][PIX_W-1:0] patch;
  } ring_t;

  typedef struct packed {
    logic [DIRS-1:0] bits;
  } code_t;

  typedef struct packed {
    logic [LBL_W-1:0] ni;
    logic [LBL_W-1:0] rd;
  } label_t;

  // pull both rings and the flat patch out of a window
  function automatic ring_t get_ring(window_t w);
    ring_t r;
    for (int k = 0; k < DIRS; k++) begin
      r.r1[k] = w.px[WIN_C + DIR_DR[k]][WIN_C + DIR_DC[k]];
      r.r2[k] = w.px[WIN_C + 2 * DIR_DR[k]][WIN_C + 2 * DIR_DC[k]];
    end
    for (int i = 0; i < PATCH_N; i++) begin
      r.patch[i] = w.px[i / WIN_N][i % WIN_N];
    end
    return r;
  endfunction

endpackage
